/* src/timer_macros.svh */
`ifndef TIMER_MACROS_SVH
`define TIMER_MACROS_SVH

// APB byte address width.
`define TIMER_ADDR_WIDTH 5

// Register and bus data width.
`define TIMER_DATA_WIDTH 32

// Word register slots behind the bus interface.
`define TIMER_REG_NUM 8

// Constant returned by the ID register.
`define TIMER_ID_VALUE 32'h5449_4d31

`endif

/* src/apb_pkg.sv */
`default_nettype none
`include "timer_macros.svh"

package apb_pkg;

    // Request from the APB master. Address, write and wdata hold through the access phase.
    typedef struct packed {
        logic                         sel;
        logic                         enable;
        logic                         write;   // 1 for write, 0 for read.
        logic [`TIMER_ADDR_WIDTH-1:0] addr;
        logic [`TIMER_DATA_WIDTH-1:0] wdata;
    } apb_req_t;

    // Response back to the master.
    typedef struct packed {
        logic [`TIMER_DATA_WIDTH-1:0] rdata;
        logic                         ready;
    } apb_rsp_t;

endpackage

`default_nettype wire

/* src/timer_pkg.sv */
`default_nettype none
`include "timer_macros.svh"

package timer_pkg;

    typedef logic [$clog2(`TIMER_REG_NUM)-1:0] reg_idx_t;

    // Word register map.
    localparam reg_idx_t REG_CTRL   = 3'd0;
    localparam reg_idx_t REG_PERIOD = 3'd1;
    localparam reg_idx_t REG_COUNT  = 3'd2; // Read only.
    localparam reg_idx_t REG_STATUS = 3'd3; // Write 1 to clear.
    localparam reg_idx_t REG_ID     = 3'd4; // Read only.

    // Bit positions inside CTRL and STATUS.
    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_IRQ_EN_BIT = 1;
    localparam int STATUS_WRAP_BIT = 0;

    // One-cycle register write from the bus interface.
    typedef struct packed {
        logic                         wen;
        reg_idx_t                     idx;
        logic [`TIMER_DATA_WIDTH-1:0] wdata;
    } reg_wr_t;

    // Configuration steering the counter.
    typedef struct packed {
        logic                         enable;
        logic [`TIMER_DATA_WIDTH-1:0] period;
    } timer_cfg_t;

    // Counter state back to the registers.
    typedef struct packed {
        logic [`TIMER_DATA_WIDTH-1:0] count;
        logic                         wrap;  // High for the cycle the counter wraps.
    } timer_stat_t;

endpackage

`default_nettype wire

/* src/apb_reg_if.sv */
`default_nettype none
`include "timer_macros.svh"

module apb_reg_if #(
    parameter int REG_NUM = `TIMER_REG_NUM
) (
    input  wire logic                         clk,
    input  wire logic                         resetn,

    input  wire apb_pkg::apb_req_t            req,
    output apb_pkg::apb_rsp_t                 rsp,

    output timer_pkg::reg_wr_t                reg_wr,
    output timer_pkg::reg_idx_t               rd_idx,
    input  wire logic [`TIMER_DATA_WIDTH-1:0] rd_data
);

    localparam int BYTE_LSB = $clog2(`TIMER_DATA_WIDTH / 8);
    localparam int IDX_W    = $clog2(REG_NUM);

    typedef enum logic {
        ST_IDLE,
        ST_ACCESS
    } state_t;

    state_t                       state_q;
    logic                         setup;
    logic                         wen_q;
    timer_pkg::reg_idx_t          wr_idx_q;
    logic [`TIMER_DATA_WIDTH-1:0] wr_data_q;
    logic [`TIMER_DATA_WIDTH-1:0] rdata_q;

    // Setup phase seen while idle.
    assign setup = (state_q == ST_IDLE) && req.sel && !req.enable;

    // Word index, so the read mux settles inside the setup cycle.
    assign rd_idx = timer_pkg::reg_idx_t'(req.addr[BYTE_LSB +: IDX_W]);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= ST_IDLE;
            wen_q   <= 1'b0;
            rdata_q <= '0;
        end else begin
            wen_q <= setup && req.write; // Single-cycle strobe during access.
            case (state_q)
                ST_IDLE: begin
                    if (setup) begin
                        state_q <= ST_ACCESS;
                    end
                end
                ST_ACCESS: begin
                    state_q <= ST_IDLE;
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
            if (setup && !req.write) begin
                rdata_q <= rd_data;
            end
        end
    end

    // Write payload, only meaningful while wen_q is high.
    always_ff @(posedge clk) begin
        if (setup && req.write) begin
            wr_idx_q  <= rd_idx;
            wr_data_q <= req.wdata;
        end
    end

    assign reg_wr = '{wen: wen_q, idx: wr_idx_q, wdata: wr_data_q};

    // Ready is high for exactly the access cycle.
    assign rsp = '{rdata: rdata_q, ready: (state_q == ST_ACCESS)};

endmodule

`default_nettype wire

/* src/timer_regs.sv */
`default_nettype none
`include "timer_macros.svh"

module timer_regs (
    input  wire logic                  clk,
    input  wire logic                  resetn,

    input  wire timer_pkg::reg_wr_t    reg_wr,
    input  wire timer_pkg::reg_idx_t   rd_idx,
    output logic [`TIMER_DATA_WIDTH-1:0] rd_data,

    output timer_pkg::timer_cfg_t      cfg,
    input  wire timer_pkg::timer_stat_t stat,
    output logic                       irq
);

    logic                         enable_q;
    logic                         irq_en_q;
    logic [`TIMER_DATA_WIDTH-1:0] period_q;
    logic                         status_q;
    logic                         irq_q;
    logic                         wr_ctrl;
    logic                         wr_period;
    logic                         clr_status;

    assign wr_ctrl    = reg_wr.wen && (reg_wr.idx == timer_pkg::REG_CTRL);
    assign wr_period  = reg_wr.wen && (reg_wr.idx == timer_pkg::REG_PERIOD);
    assign clr_status = reg_wr.wen && (reg_wr.idx == timer_pkg::REG_STATUS)
                        && reg_wr.wdata[timer_pkg::STATUS_WRAP_BIT];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            enable_q <= 1'b0;
            irq_en_q <= 1'b0;
            period_q <= '0;
            status_q <= 1'b0;
            irq_q    <= 1'b0;
        end else begin
            if (wr_ctrl) begin
                enable_q <= reg_wr.wdata[timer_pkg::CTRL_ENABLE_BIT];
                irq_en_q <= reg_wr.wdata[timer_pkg::CTRL_IRQ_EN_BIT];
            end
            if (wr_period) begin
                period_q <= reg_wr.wdata;
            end
            // A wrap in the same cycle as a clear keeps the flag set.
            status_q <= stat.wrap || (status_q && !clr_status);
            irq_q    <= status_q && irq_en_q;
        end
    end

    assign cfg = '{enable: enable_q, period: period_q};
    assign irq = irq_q;

    always_comb begin
        rd_data = '0; // Unmapped slots read zero.
        case (rd_idx)
            timer_pkg::REG_CTRL: begin
                rd_data[timer_pkg::CTRL_ENABLE_BIT] = enable_q;
                rd_data[timer_pkg::CTRL_IRQ_EN_BIT] = irq_en_q;
            end
            timer_pkg::REG_PERIOD: rd_data = period_q;
            timer_pkg::REG_COUNT:  rd_data = stat.count;
            timer_pkg::REG_STATUS: rd_data[timer_pkg::STATUS_WRAP_BIT] = status_q;
            timer_pkg::REG_ID:     rd_data = `TIMER_ID_VALUE;
            default: begin
                rd_data = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/timer_core.sv */
`default_nettype none
`include "timer_macros.svh"

module timer_core (
    input  wire logic                  clk,
    input  wire logic                  resetn,

    input  wire timer_pkg::timer_cfg_t cfg,
    output timer_pkg::timer_stat_t     stat
);

    logic [`TIMER_DATA_WIDTH-1:0] count_q;
    logic                         at_period;
    logic                         wrap;

    assign at_period = (count_q == cfg.period);

    // Wrap is flagged in the cycle the count sits on the period.
    assign wrap = cfg.enable && at_period;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            count_q <= '0;
        end else if (cfg.enable) begin
            if (at_period) begin
                count_q <= '0;
            end else begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    assign stat = '{count: count_q, wrap: wrap};

endmodule

`default_nettype wire

/* src/apb_timer.sv */
`default_nettype none
`include "timer_macros.svh"

module apb_timer (
    input  wire logic              clk,
    input  wire logic              resetn,

    input  wire apb_pkg::apb_req_t req,
    output apb_pkg::apb_rsp_t      rsp,
    output logic                   irq
);

    timer_pkg::reg_wr_t           reg_wr;
    timer_pkg::reg_idx_t          rd_idx;
    logic [`TIMER_DATA_WIDTH-1:0] rd_data;
    timer_pkg::timer_cfg_t        cfg;
    timer_pkg::timer_stat_t       stat;

    apb_reg_if #(
        .REG_NUM (`TIMER_REG_NUM)
    ) apb_reg_if_inst (
        .clk     (clk),
        .resetn  (resetn),
        .req     (req),
        .rsp     (rsp),
        .reg_wr  (reg_wr),
        .rd_idx  (rd_idx),
        .rd_data (rd_data)
    );

    timer_regs timer_regs_inst (
        .clk     (clk),
        .resetn  (resetn),
        .reg_wr  (reg_wr),
        .rd_idx  (rd_idx),
        .rd_data (rd_data),
        .cfg     (cfg),
        .stat    (stat),
        .irq     (irq)
    );

    timer_core timer_core_inst (
        .clk    (clk),
        .resetn (resetn),
        .cfg    (cfg),
        .stat   (stat)
    );

endmodule

`default_nettype wire

/* test/tb_apb_timer.sv */
`default_nettype none
`include "timer_macros.svh"

module tb_apb_timer;

    localparam int MAX_CYCLES = 3000; // Well above what the tests need.

    logic              clk;
    logic              resetn;
    apb_pkg::apb_req_t req;
    apb_pkg::apb_rsp_t rsp;
    logic              irq;

    int     errors          = 0;
    int     protocol_errors = 0;
    int     cycles          = 0;
    integer seed;

    apb_timer apb_timer_inst (
        .clk    (clk),
        .resetn (resetn),
        .req    (req),
        .rsp    (rsp),
        .irq    (irq)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run went past %0d cycles without finishing", MAX_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Ready must be high in the access cycle and nowhere else.
    ready_in_access: assert property (@(negedge clk) disable iff (!resetn)
        rsp.ready == (req.sel && req.enable))
    else begin
        protocol_errors++;
        $display("Protocol error at %0t: ready was not high exactly in the access cycle",
                 $time);
    end

    task automatic check_equal(input string what, input logic [`TIMER_DATA_WIDTH-1:0] got,
                               input logic [`TIMER_DATA_WIDTH-1:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    // Starts one cycle after the previous transfer, so transfers run back to back.
    task automatic apb_transfer(input logic write, input timer_pkg::reg_idx_t idx,
                                input logic [`TIMER_DATA_WIDTH-1:0] wdata,
                                output logic [`TIMER_DATA_WIDTH-1:0] rdata);
        req.sel    = 1'b1;  // Setup phase.
        req.enable = 1'b0;
        req.write  = write;
        req.addr   = {idx, 2'b00};
        req.wdata  = wdata;
        @(posedge clk);
        #1;
        req.enable = 1'b1;  // Access phase.
        rdata      = rsp.rdata;
        @(posedge clk);
        #1;
        req.sel    = 1'b0;
        req.enable = 1'b0;
    endtask

    task automatic apb_write(input timer_pkg::reg_idx_t idx,
                             input logic [`TIMER_DATA_WIDTH-1:0] wdata);
        logic [`TIMER_DATA_WIDTH-1:0] unused;
        apb_transfer(1'b1, idx, wdata, unused);
    endtask

    task automatic apb_read(input timer_pkg::reg_idx_t idx,
                            output logic [`TIMER_DATA_WIDTH-1:0] rdata);
        apb_transfer(1'b0, idx, '0, rdata);
    endtask

    initial begin
        logic [`TIMER_DATA_WIDTH-1:0] data;
        logic [`TIMER_DATA_WIDTH-1:0] first;
        logic [`TIMER_DATA_WIDTH-1:0] rnd;
        logic [`TIMER_DATA_WIDTH-1:0] last_period;
        int                           polls;

        seed   = 62159;
        req    = '0;
        resetn = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        resetn = 1'b1;

        // Reset values.
        check_equal("irq after reset", {31'b0, irq}, '0);
        apb_read(timer_pkg::REG_CTRL, data);
        check_equal("CTRL after reset", data, '0);
        apb_read(timer_pkg::REG_PERIOD, data);
        check_equal("PERIOD after reset", data, '0);
        apb_read(timer_pkg::REG_COUNT, data);
        check_equal("COUNT after reset", data, '0);
        apb_read(timer_pkg::REG_STATUS, data);
        check_equal("STATUS after reset", data, '0);
        apb_read(timer_pkg::REG_ID, data);
        check_equal("ID", data, `TIMER_ID_VALUE);

        // Read-only registers ignore writes.
        apb_write(timer_pkg::REG_COUNT, $random(seed));
        apb_read(timer_pkg::REG_COUNT, data);
        check_equal("COUNT after write", data, '0);
        apb_write(timer_pkg::REG_ID, $random(seed));
        apb_read(timer_pkg::REG_ID, data);
        check_equal("ID after write", data, `TIMER_ID_VALUE);

        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            apb_write(timer_pkg::REG_PERIOD, rnd);
            apb_read(timer_pkg::REG_PERIOD, data);
            check_equal("PERIOD read-back", data, rnd);
            last_period = rnd;
            rnd = $random(seed) & ~32'h1; // Keep the counter stopped.
            apb_write(timer_pkg::REG_CTRL, rnd);
            apb_read(timer_pkg::REG_CTRL, data);
            check_equal("CTRL read-back", data, rnd & 32'h3);
        end

        // Unmapped slots.
        for (int i = 5; i < 8; i++) begin
            apb_write(timer_pkg::reg_idx_t'(i), $random(seed));
            apb_read(timer_pkg::reg_idx_t'(i), data);
            check_equal("unmapped slot", data, '0);
        end
        apb_read(timer_pkg::REG_PERIOD, data);
        check_equal("PERIOD after unmapped writes", data, last_period);
        apb_read(timer_pkg::REG_CTRL, data);
        check_equal("CTRL after unmapped writes", data, rnd & 32'h3);

        // Counting up to the period and raising irq.
        apb_write(timer_pkg::REG_PERIOD, 32'd20);
        apb_write(timer_pkg::REG_CTRL, 32'h3);
        polls = 0;
        while (!irq && polls < 20) begin
            apb_read(timer_pkg::REG_COUNT, data);
            assert (data <= 32'd20) else begin
                errors++;
                $display("Mismatch at %0t: COUNT 0x%08h is above the period", $time, data);
            end
            polls++;
        end
        assert (irq) else begin
            errors++;
            $display("Error at %0t: irq did not rise within 40 cycles of enabling", $time);
        end
        apb_read(timer_pkg::REG_STATUS, data);
        check_equal("STATUS after wrap", data, 32'h1);

        // Write 1 to clear, counter stopped but irq still enabled.
        apb_write(timer_pkg::REG_CTRL, 32'h2);
        apb_write(timer_pkg::REG_STATUS, 32'h0);
        apb_read(timer_pkg::REG_STATUS, data);
        check_equal("STATUS after writing 0", data, 32'h1);
        apb_write(timer_pkg::REG_STATUS, 32'h1);
        repeat (2) @(posedge clk);
        #1;
        check_equal("irq after clear", {31'b0, irq}, '0);
        apb_read(timer_pkg::REG_STATUS, data);
        check_equal("STATUS after clear", data, '0);

        // Count holds while disabled.
        apb_read(timer_pkg::REG_COUNT, first);
        apb_read(timer_pkg::REG_COUNT, data);
        check_equal("COUNT while disabled", data, first);

        // Wraps with irq_en low never reach irq.
        apb_write(timer_pkg::REG_CTRL, 32'h1);
        apb_read(timer_pkg::REG_CTRL, data);
        check_equal("CTRL with only enable", data, 32'h1);
        data  = '0;
        polls = 0;
        while (data == '0 && polls < 20) begin
            apb_read(timer_pkg::REG_STATUS, data);
            check_equal("irq with irq_en low", {31'b0, irq}, '0);
            polls++;
        end
        check_equal("STATUS after second wrap", data, 32'h1);
        repeat (3) @(posedge clk);
        #1;
        check_equal("irq after second wrap", {31'b0, irq}, '0);
        apb_write(timer_pkg::REG_CTRL, 32'h0);

        $display("Errors: %0d value, %0d protocol", errors, protocol_errors);
        if (errors == 0 && protocol_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+src
src/apb_pkg.sv
src/timer_pkg.sv
src/apb_reg_if.sv
src/timer_regs.sv
src/timer_core.sv
src/apb_timer.sv
test/tb_apb_timer.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_apb_timer -f project.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vtb_apb_timer)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1
